//--- src/cdp_rdma_pkg.sv
// cdp read dma ingress types
package cdp_rdma_pkg;

  // ========================================
  // field widths
  // ========================================

  // full memory byte address
  typedef logic [63:0] addr_t;

  // line or surface stride in bytes
  typedef logic [31:0] stride_t;

  // cube dimension, value is count minus one
  typedef logic [12:0] dim_t;

  // request size in atoms minus one, 0..7
  typedef logic [2:0] req_size_t;

  // stall cycle count
  typedef logic [31:0] perf_t;

  // ========================================
  // width grouping
  // ========================================

  // max atoms per width group
  localparam int GROUP_ATOMS = 8;

  // log2 of GROUP_ATOMS
  localparam int GROUP_SHIFT = 3;

  // width group index
  // 8192 atoms / 8 = 1024 groups max
  typedef logic [10:0] wgrp_cnt_t;

endpackage

//--- src/cdp_walk_if.sv
// cube walk position bundle
interface cdp_walk_if;
  import cdp_rdma_pkg::*;

  // end flags of the current request
  logic      last_w;
  logic      last_h;
  logic      last_c;
  // atoms minus one of the current request
  req_size_t req_size;
  // request taken by both memory port and context queue
  logic      accept;

  // cube walker side
  modport walker (output last_w, last_h, last_c, req_size, input accept);

  // address generator side, read only
  modport addr_user (input last_w, last_h, last_c, req_size, accept);

  // layer control side
  modport ctrl (output accept);

endinterface

//--- src/cdp_rdma_layer_ctrl.sv
// layer start and done control
module cdp_rdma_layer_ctrl (
  input  logic    nvdla_core_clk,
  input  logic    nvdla_core_rstn,
  input  logic    op_en,
  input  logic    eg2ig_done,
  input  logic    cube_end,
  input  logic    rd_req_ready,
  input  logic    cq_wr_prdy,
  cdp_walk_if.ctrl walk,
  output logic    op_load,
  output logic    rd_req_valid,
  output logic    cq_wr_pvld
);

  // cube in progress
  logic tran_vld;
  // last request sent, egress still draining
  logic wait_eg;
  logic op_done;

  // ========================================
  // layer start / end
  // ========================================

  // no reload while busy or while egress is behind
  assign op_load = op_en & ~tran_vld & ~wait_eg;
  assign op_done = walk.accept & cube_end;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      tran_vld <= 1'b0;
    end else if (op_done) begin
      tran_vld <= 1'b0;
    end else if (op_load) begin
      tran_vld <= 1'b1;
    end
  end

  // set at cube end, released by egress done
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wait_eg <= 1'b0;
    end else if (op_done) begin
      wait_eg <= 1'b1;
    end else if (eg2ig_done) begin
      wait_eg <= 1'b0;
    end
  end

  // ========================================
  // joint handshake
  // ========================================

  // each side only sees valid when the other can take it
  assign rd_req_valid = tran_vld & cq_wr_prdy;
  assign cq_wr_pvld   = tran_vld & rd_req_ready;
  // both sides taken in the same cycle
  assign walk.accept  = tran_vld & rd_req_ready & cq_wr_prdy;

endmodule

//--- src/cdp_rdma_cube_walker.sv
// feature cube position counters
module cdp_rdma_cube_walker #(
  parameter int ATOM_SHIFT = 5
) (
  input  logic                nvdla_core_clk,
  input  logic                nvdla_core_rstn,
  input  cdp_rdma_pkg::dim_t  width,
  input  cdp_rdma_pkg::dim_t  height,
  input  cdp_rdma_pkg::dim_t  channel,
  cdp_walk_if.walker          walk,
  output logic                cube_end
);
  import cdp_rdma_pkg::*;

  // channel atom counter width
  localparam int CHN_W = $bits(dim_t) - ATOM_SHIFT;

  logic [CHN_W-1:0]   chn_cnt;
  wgrp_cnt_t          wgrp_cnt;
  dim_t               hgt_cnt;
  // width in atoms, one bit wider than dim_t
  logic [$bits(dim_t):0] width_use;
  logic [$bits(dim_t):0] width_rnd;
  wgrp_cnt_t          num_grp;
  logic               first_w;
  logic               line_end;
  req_size_t          tail_size;

  // ========================================
  // width grouping
  // ========================================

  assign width_use = {1'b0, width} + 1'b1;
  // round up to whole groups
  assign width_rnd = width_use + ($bits(width_rnd))'(GROUP_ATOMS - 1);
  assign num_grp   = wgrp_cnt_t'(width_rnd >> GROUP_SHIFT);
  // atoms in the final partial group, minus one
  assign tail_size = width[GROUP_SHIFT-1:0];

  // ========================================
  // position flags
  // ========================================

  assign walk.last_c = (chn_cnt == channel[$bits(dim_t)-1:ATOM_SHIFT]);
  assign walk.last_w = (wgrp_cnt == num_grp - 1'b1);
  assign walk.last_h = (hgt_cnt == height);
  assign first_w     = (wgrp_cnt == '0);
  // all channels of the last group done
  assign line_end    = walk.last_c & walk.last_w;
  assign cube_end    = line_end & walk.last_h;

  // request size
  // single group case goes through first_w
  always_comb begin
    if (first_w) begin
      walk.req_size = (num_grp == 1) ? tail_size : req_size_t'(GROUP_ATOMS - 1);
    end else if (walk.last_w) begin
      walk.req_size = tail_size;
    end else begin
      walk.req_size = req_size_t'(GROUP_ATOMS - 1);
    end
  end

  // ========================================
  // counters, w8 -> c -> h
  // ========================================

  // channel atom, innermost
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      chn_cnt <= '0;
    end else if (walk.accept) begin
      if (walk.last_c) begin
        chn_cnt <= '0;
      end else begin
        chn_cnt <= chn_cnt + 1'b1;
      end
    end
  end

  // width group, steps after the channel sweep
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wgrp_cnt <= '0;
    end else if (walk.accept) begin
      if (line_end) begin
        wgrp_cnt <= '0;
      end else if (walk.last_c) begin
        wgrp_cnt <= wgrp_cnt + 1'b1;
      end
    end
  end

  // line, outermost
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      hgt_cnt <= '0;
    end else if (walk.accept) begin
      if (cube_end) begin
        hgt_cnt <= '0;
      end else if (line_end) begin
        hgt_cnt <= hgt_cnt + 1'b1;
      end
    end
  end

endmodule

//--- src/cdp_rdma_addr_gen.sv
// read request address generator
module cdp_rdma_addr_gen #(
  parameter int ATOM_SHIFT = 5
) (
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  input  logic                   op_load,
  input  cdp_rdma_pkg::addr_t    base_addr,
  input  cdp_rdma_pkg::stride_t  line_stride,
  input  cdp_rdma_pkg::stride_t  surf_stride,
  cdp_walk_if.addr_user          walk,
  output cdp_rdma_pkg::addr_t    rd_req_addr
);
  import cdp_rdma_pkg::*;

  // start of current line
  addr_t              line_base;
  // start of current width group
  addr_t              grp_base;
  addr_t              req_addr;
  // atoms in current request, 1..8
  logic [GROUP_SHIFT:0] size_use;
  addr_t              grp_next;
  addr_t              line_next;

  // ========================================
  // next base candidates
  // ========================================

  assign size_use  = {1'b0, walk.req_size} + 1'b1;
  // skip past the atoms just fetched
  assign grp_next  = grp_base + (addr_t'(size_use) << ATOM_SHIFT);
  assign line_next = line_base + addr_t'(line_stride);

  // ========================================
  // address registers
  // ========================================

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      line_base <= '0;
      grp_base  <= '0;
      req_addr  <= '0;
    end else if (op_load) begin
      line_base <= base_addr;
      grp_base  <= base_addr;
      req_addr  <= base_addr;
    end else if (walk.accept) begin
      if (!walk.last_c) begin
        // next channel surface, same group
        req_addr <= req_addr + addr_t'(surf_stride);
      end else if (!walk.last_w) begin
        // next group on the same line
        grp_base <= grp_next;
        req_addr <= grp_next;
      end else begin
        // wrap to the next line
        line_base <= line_next;
        grp_base  <= line_next;
        req_addr  <= line_next;
      end
    end
  end

  assign rd_req_addr = req_addr;

endmodule

//--- src/cdp_rdma_stall_perf.sv
// read stall performance counter
module cdp_rdma_stall_perf (
  input  logic                nvdla_core_clk,
  input  logic                nvdla_core_rstn,
  input  logic                dma_en,
  input  logic                stall,
  input  logic                clear,
  output cdp_rdma_pkg::perf_t perf_d0,
  output cdp_rdma_pkg::perf_t perf_d1
);
  import cdp_rdma_pkg::*;

  perf_t stl_cnt;
  perf_t stl_inc;
  // count including this cycle
  perf_t stl_cur;
  logic  cnt_en;
  // selects d0 or d1 for the next cube
  logic  layer_flag;

  // ========================================
  // stall counter
  // ========================================

  assign cnt_en  = dma_en & stall;
  // hold at all ones
  assign stl_inc = (stl_cnt == '1) ? stl_cnt : stl_cnt + 1'b1;
  assign stl_cur = cnt_en ? stl_inc : stl_cnt;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      stl_cnt <= '0;
    end else if (clear) begin
      stl_cnt <= '0;
    end else if (cnt_en) begin
      stl_cnt <= stl_inc;
    end
  end

  // ========================================
  // ping-pong result registers
  // ========================================

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      layer_flag <= 1'b0;
      perf_d0    <= '0;
      perf_d1    <= '0;
    end else if (clear) begin
      layer_flag <= ~layer_flag;
      if (layer_flag) begin
        perf_d1 <= stl_cur;
      end else begin
        perf_d0 <= stl_cur;
      end
    end
  end

endmodule

//--- src/cdp_rdma_ig.sv
// cdp read dma ingress top
module cdp_rdma_ig #(
  parameter int ATOM_SHIFT = 5
) (
  input  logic                      nvdla_core_clk,
  input  logic                      nvdla_core_rstn,
  // layer control
  input  logic                      op_en,
  input  logic                      dma_en,
  input  logic                      eg2ig_done,
  // cube config
  input  cdp_rdma_pkg::dim_t        width,
  input  cdp_rdma_pkg::dim_t        height,
  input  cdp_rdma_pkg::dim_t        channel,
  input  logic [31:0]               base_addr_high,
  input  logic [31:0]               base_addr_low,
  input  cdp_rdma_pkg::stride_t     line_stride,
  input  cdp_rdma_pkg::stride_t     surf_stride,
  // memory read request
  input  logic                      rd_req_ready,
  output logic                      rd_req_valid,
  output cdp_rdma_pkg::addr_t       rd_req_addr,
  output cdp_rdma_pkg::req_size_t   rd_req_size,
  // context queue write
  input  logic                      cq_wr_prdy,
  output logic                      cq_wr_pvld,
  output cdp_rdma_pkg::req_size_t   cq_wr_size,
  output logic                      cq_wr_last_w,
  output logic                      cq_wr_last_h,
  output logic                      cq_wr_last_c,
  // stall counts, alternating per layer
  output cdp_rdma_pkg::perf_t       perf_read_stall_d0,
  output cdp_rdma_pkg::perf_t       perf_read_stall_d1
);
  import cdp_rdma_pkg::*;

  addr_t base_addr;
  logic  op_load;
  logic  cube_end;

  cdp_walk_if walk ();

  assign base_addr = {base_addr_high, base_addr_low};

  // ========================================
  // control and walk
  // ========================================

  cdp_rdma_layer_ctrl u_layer_ctrl (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_en           (op_en),
    .eg2ig_done      (eg2ig_done),
    .cube_end        (cube_end),
    .rd_req_ready    (rd_req_ready),
    .cq_wr_prdy      (cq_wr_prdy),
    .walk            (walk.ctrl),
    .op_load         (op_load),
    .rd_req_valid    (rd_req_valid),
    .cq_wr_pvld      (cq_wr_pvld)
  );

  cdp_rdma_cube_walker #(.ATOM_SHIFT(ATOM_SHIFT)) u_cube_walker (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .width           (width),
    .height          (height),
    .channel         (channel),
    .walk            (walk.walker),
    .cube_end        (cube_end)
  );

  cdp_rdma_addr_gen #(.ATOM_SHIFT(ATOM_SHIFT)) u_addr_gen (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .base_addr       (base_addr),
    .line_stride     (line_stride),
    .surf_stride     (surf_stride),
    .walk            (walk.addr_user),
    .rd_req_addr     (rd_req_addr)
  );

  // stall counts only while valid is held off by the memory port
  cdp_rdma_stall_perf u_stall_perf (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .dma_en          (dma_en),
    .stall           (rd_req_valid & ~rd_req_ready),
    .clear           (walk.accept & cube_end),
    .perf_d0         (perf_read_stall_d0),
    .perf_d1         (perf_read_stall_d1)
  );

  // ========================================
  // request payloads
  // ========================================

  assign rd_req_size  = walk.req_size;
  assign cq_wr_size   = walk.req_size;
  assign cq_wr_last_w = walk.last_w;
  assign cq_wr_last_h = walk.last_h;
  assign cq_wr_last_c = walk.last_c;

endmodule

//--- dv/tb_cdp_rdma_ig.sv
// cdp read dma ingress testbench
module tb_cdp_rdma_ig;
  import cdp_rdma_pkg::*;

  localparam int ATOM_SHIFT  = 5;
  localparam int CYCLE_LIMIT = 5000;
  localparam int IDLE_CYCLES = 8;

  logic      nvdla_core_clk;
  logic      nvdla_core_rstn;
  logic      op_en;
  logic      dma_en;
  logic      eg2ig_done;
  dim_t      width;
  dim_t      height;
  dim_t      channel;
  logic [31:0] base_addr_high;
  logic [31:0] base_addr_low;
  stride_t   line_stride;
  stride_t   surf_stride;
  logic      rd_req_ready;
  logic      rd_req_valid;
  addr_t     rd_req_addr;
  req_size_t rd_req_size;
  logic      cq_wr_prdy;
  logic      cq_wr_pvld;
  req_size_t cq_wr_size;
  logic      cq_wr_last_w;
  logic      cq_wr_last_h;
  logic      cq_wr_last_c;
  perf_t     perf_read_stall_d0;
  perf_t     perf_read_stall_d1;

  // expected request stream, flags as {w, h, c}
  addr_t       exp_addr[$];
  req_size_t   exp_size[$];
  logic [2:0]  exp_flags[$];
  // layer parity picks the perf slot
  int          layer_cnt;
  perf_t       exp_d0;
  perf_t       exp_d1;
  bit          done_pending;

  cdp_rdma_ig #(.ATOM_SHIFT(ATOM_SHIFT)) UUT (.*);

  initial begin
    nvdla_core_clk = 1'b0;
    forever #20 nvdla_core_clk = ~nvdla_core_clk;
  end

  // ========================================
  // error handling and compares
  // ========================================

  task automatic stop_on_error();
    $display("Finished with errors");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s addr 0x%0h, expected 0x%0h", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_size(input req_size_t got, input req_size_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s size %0d, expected %0d", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_flags(input logic [2:0] got, input logic [2:0] exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s flags w/h/c %b, expected %b", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_perf(input perf_t got, input perf_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s stall count %0d, expected %0d", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  // ========================================
  // reference model
  // ========================================

  // walk order is width group, then channel atom, then line
  task automatic build_model(input addr_t base, input dim_t w, input dim_t h, input dim_t c,
                             input stride_t ls, input stride_t ss);
    int        ngrp;
    int        nchn;
    addr_t     grp;
    req_size_t sz;
    exp_addr.delete();
    exp_size.delete();
    exp_flags.delete();
    // (w + 1 + 7) / 8 groups
    ngrp = (int'(w) + GROUP_ATOMS) / GROUP_ATOMS;
    nchn = (int'(c) >> ATOM_SHIFT) + 1;
    for (int hi = 0; hi <= int'(h); hi++) begin
      grp = base + addr_t'(hi) * addr_t'(ls);
      for (int g = 0; g < ngrp; g++) begin
        // only the final group of a line is partial
        sz = (g == ngrp - 1) ? w[2:0] : req_size_t'(GROUP_ATOMS - 1);
        for (int ci = 0; ci < nchn; ci++) begin
          exp_addr.push_back(grp + addr_t'(ci) * addr_t'(ss));
          exp_size.push_back(sz);
          exp_flags.push_back({g == ngrp - 1, hi == int'(h), ci == nchn - 1});
        end
        grp = grp + ((addr_t'(sz) + 64'd1) << ATOM_SHIFT);
      end
    end
  endtask

  // ========================================
  // cube runner
  // ========================================

  // sample at negedge, drive readies just after posedge
  task automatic collect_cube(input bit rand_rdy, input string name, output int stalls);
    int idx;
    int timer;
    bit active;
    idx    = 0;
    timer  = 0;
    stalls = 0;
    active = 1'b0;
    while (idx < exp_addr.size()) begin
      @(negedge nvdla_core_clk);
      timer++;
      if (timer > CYCLE_LIMIT) begin
        $display("%s: timeout, request %0d of %0d never accepted", name, idx, exp_addr.size());
        stop_on_error();
      end
      // each side only offered when the other can take it
      if (rd_req_valid && !cq_wr_prdy) begin
        $display("CHECK FAILED at %0t: %s rd_req_valid with cq_wr_prdy low", $time, name);
        stop_on_error();
      end
      if (cq_wr_pvld && !rd_req_ready) begin
        $display("CHECK FAILED at %0t: %s cq_wr_pvld with rd_req_ready low", $time, name);
        stop_on_error();
      end
      // load cycle, tran_vld not yet set
      if (!active && (rd_req_valid || cq_wr_pvld)) begin
        $display("CHECK FAILED at %0t: %s request offered in the load cycle", $time, name);
        stop_on_error();
      end
      // a pending request is offered on each side the other can take
      if (active && (rd_req_valid !== cq_wr_prdy || cq_wr_pvld !== rd_req_ready)) begin
        $display("CHECK FAILED at %0t: %s request %0d not offered", $time, name, idx);
        stop_on_error();
      end
      // request waits on the memory port
      if (active && cq_wr_prdy && !rd_req_ready) begin
        stalls++;
      end
      if (active && rd_req_ready && cq_wr_prdy) begin
        check_addr(rd_req_addr, exp_addr[idx], name);
        check_size(rd_req_size, exp_size[idx], name);
        check_size(cq_wr_size, exp_size[idx], name);
        check_flags({cq_wr_last_w, cq_wr_last_h, cq_wr_last_c}, exp_flags[idx], name);
        idx++;
      end
      // first request appears the cycle after op_load
      active = 1'b1;
      @(posedge nvdla_core_clk);
      #1;
      rd_req_ready = rand_rdy ? (($urandom % 4) != 0) : 1'b1;
      cq_wr_prdy   = rand_rdy ? (($urandom % 4) != 0) : 1'b1;
    end
  endtask

  // op_en stays high, so only the egress wait holds the next layer off
  task automatic check_idle(input string name);
    repeat (IDLE_CYCLES) begin
      @(negedge nvdla_core_clk);
      if (rd_req_valid || cq_wr_pvld) begin
        $display("%s: request offered after cube end before eg2ig_done", name);
        stop_on_error();
      end
    end
  endtask

  task automatic run_layer(input addr_t base, input dim_t w, input dim_t h, input dim_t c,
                           input bit rand_rdy, input bit dma, input string name);
    int stalls;
    @(posedge nvdla_core_clk);
    #1;
    base_addr_high = base[63:32];
    base_addr_low  = base[31:0];
    width          = w;
    height         = h;
    channel        = c;
    dma_en         = dma;
    op_en          = 1'b1;
    build_model(base, w, h, c, line_stride, surf_stride);
    // release the previous layer
    if (done_pending) begin
      eg2ig_done = 1'b1;
      @(posedge nvdla_core_clk);
      #1;
      eg2ig_done = 1'b0;
    end
    collect_cube(rand_rdy, name, stalls);
    rd_req_ready = 1'b1;
    cq_wr_prdy   = 1'b1;
    check_idle(name);
    done_pending = 1'b1;
    if (layer_cnt % 2 == 0) begin
      exp_d0 = dma ? perf_t'(stalls) : '0;
    end else begin
      exp_d1 = dma ? perf_t'(stalls) : '0;
    end
    layer_cnt++;
    check_perf(perf_read_stall_d0, exp_d0, {name, " d0"});
    check_perf(perf_read_stall_d1, exp_d1, {name, " d1"});
    $display("%s: %0d requests, %0d stall cycles", name, exp_addr.size(), stalls);
  endtask

  // ========================================
  // directed tests
  // ========================================

  task automatic after_reset_idle();
    @(negedge nvdla_core_clk);
    if (rd_req_valid || cq_wr_pvld) begin
      $display("valid output active right after reset");
      stop_on_error();
    end
    check_perf(perf_read_stall_d0, '0, "reset d0");
    check_perf(perf_read_stall_d1, '0, "reset d1");
  endtask

  // 21 atoms in 3 groups, 3 channel atoms, 3 lines
  task automatic full_ready_cube();
    run_layer(64'h0000_0001_0000_1000, 13'd20, 13'd2, 13'd95, 1'b0, 1'b1, "full ready");
  endtask

  // 5 atoms fit in one group
  task automatic small_width_cube();
    run_layer(64'h0000_0000_8000_0000, 13'd4, 13'd1, 13'd70, 1'b0, 1'b1, "small width");
  endtask

  // same cube as full ready, twice, so both perf slots see stalls
  task automatic random_ready_cube();
    run_layer(64'h0000_0001_0000_1000, 13'd20, 13'd2, 13'd95, 1'b1, 1'b1, "random ready a");
    run_layer(64'h0000_0001_0000_1000, 13'd20, 13'd2, 13'd95, 1'b1, 1'b1, "random ready b");
  endtask

  task automatic no_dma_cube();
    run_layer(64'h0000_0002_0000_0000, 13'd15, 13'd1, 13'd63, 1'b1, 1'b0, "dma off");
  endtask

  initial begin
    void'($urandom(98980));
    layer_cnt       = 0;
    exp_d0          = '0;
    exp_d1          = '0;
    done_pending    = 1'b0;
    nvdla_core_rstn = 1'b0;
    op_en           = 1'b0;
    dma_en          = 1'b0;
    eg2ig_done      = 1'b0;
    width           = '0;
    height          = '0;
    channel         = '0;
    base_addr_high  = '0;
    base_addr_low   = '0;
    line_stride     = 32'h0000_1000;
    surf_stride     = 32'h0002_0000;
    rd_req_ready    = 1'b1;
    cq_wr_prdy      = 1'b1;
    repeat (8) @(posedge nvdla_core_clk);
    #1;
    nvdla_core_rstn = 1'b1;

    after_reset_idle();
    full_ready_cube();
    small_width_cube();
    random_ready_cube();
    no_dma_cube();

    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- cdp_rdma_ig.f
src/cdp_rdma_pkg.sv
src/cdp_walk_if.sv
src/cdp_rdma_layer_ctrl.sv
src/cdp_rdma_cube_walker.sv
src/cdp_rdma_addr_gen.sv
src/cdp_rdma_stall_perf.sv
src/cdp_rdma_ig.sv
dv/tb_cdp_rdma_ig.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -sv -Wno-fatal -j 0
TOP       := tb_cdp_rdma_ig
FILELIST  := cdp_rdma_ig.f
OBJ_DIR   := obj_dir
PASS_MSG  := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -Fxq "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
